// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = rob_tb
FILELIST = sim.f

BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = PASS: all tests
SRCS     = $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: hw/rob_alloc.sv
// Allocation side of the reorder buffer
// Owns the tail pointer and occupancy, hands out indices and accepts dispatch

`default_nettype none

`include "rob_params.svh"

module rob_alloc (
    input  wire                                  clock,
    input  wire                                  reset,
    input  wire  [`ROB_N-1:0]                    dispatch_valid,
    input  wire  [`ROB_CNT_W-1:0]                retire_count,
    input  wire                                  flush,
    input  wire  [`ROB_IDX_W-1:0]                new_tail,   // Head before this retire
    input  wire                                  recovering,
    output logic [`ROB_N-1:0][`ROB_IDX_W-1:0]    alloc_idx,
    output logic                                 dispatch_accept,
    output logic [`ROB_CNT_W-1:0]                free_slots,
    output logic [`ROB_N-1:0]                    alloc_we
);

    logic [`ROB_IDX_W-1:0] tail;
    logic [`ROB_CNT_W-1:0] count;       // Live entries
    logic [`ROB_CNT_W-1:0] valid_cnt;   // Slots asking for an entry
    logic [`ROB_CNT_W-1:0] acc_cnt;     // Slots actually written

    assign free_slots = `ROB_CNT_W'(`ROB_SZ) - count;

    // All or nothing accept
    assign dispatch_accept = !recovering && (valid_cnt <= free_slots);
    assign alloc_we        = dispatch_valid & {`ROB_N{dispatch_accept}};

    ////////////////////////////////
    // Index assignment
    ////////////////////////////////
    always_comb begin
        logic [`ROB_IDX_W-1:0] next_idx;
        next_idx  = tail;
        valid_cnt = '0;
        acc_cnt   = '0;
        for (int i = 0; i < `ROB_N; i++) begin
            alloc_idx[i] = next_idx;                       // Gaps compacted
            if (dispatch_valid[i]) begin
                next_idx  = next_idx + `ROB_IDX_W'(1);
                valid_cnt = valid_cnt + `ROB_CNT_W'(1);
            end
            acc_cnt = acc_cnt + `ROB_CNT_W'(alloc_we[i]);
        end
    end

    ////////////////////////////////
    // Tail and occupancy
    ////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // Empty buffer restarts at the advanced head
            tail  <= new_tail + retire_count[`ROB_IDX_W-1:0];
            count <= '0;
        end else begin
            tail  <= tail + acc_cnt[`ROB_IDX_W-1:0];
            count <= count + acc_cnt - retire_count;
        end
    end

endmodule

`default_nettype wire

// File: hw/rob_params.svh
// Sizing macros for the reorder buffer
// Include this in any file that sizes ports or fields of the buffer

`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Dispatch and retire width
`define ROB_N       2

// Buffer depth, kept a power of two so the pointers wrap for free
`define ROB_SZ      8
`define ROB_IDX_W   3
`define ROB_CNT_W   4     // Holds 0 to ROB_SZ

// Payload field widths
`define ROB_DATA_W  32
`define ROB_ADDR_W  32
`define ROB_REG_W   5

`endif

// File: hw/rob_pkg.sv
// Shared types for the reorder buffer
// Modules import this package for the entry layout and the enums

`default_nettype none

`include "rob_params.svh"

package rob_pkg;

    // Instruction kind as seen by the buffer
    typedef enum logic {
        kind_alu    = 1'b0,
        kind_branch = 1'b1
    } inst_kind_t;

    // Retire controller states
    typedef enum logic {
        st_run     = 1'b0,   // Normal dispatch and retire
        st_recover = 1'b1    // One cycle after a flush
    } ctrl_state_t;

    // One buffer entry
    typedef struct packed {
        logic                    valid;       // Slot holds a live instruction
        logic                    complete;    // Result has come back
        inst_kind_t              kind;
        logic [`ROB_REG_W-1:0]   dest;        // Destination register
        logic                    pred_taken;  // Front end prediction
        logic                    taken;       // Resolved direction
        logic [`ROB_DATA_W-1:0]  value;       // Result value
        logic [`ROB_ADDR_W-1:0]  target;      // Resolved branch target
    } rob_entry_t;

endpackage

`default_nettype wire

// File: hw/rob_retire_ctrl.sv
// Retire controller of the reorder buffer
// Picks the in-order retire run at the head, catches a mispredicted branch,
// and runs the one-cycle recovery after a flush

`default_nettype none

`include "rob_params.svh"

module rob_retire_ctrl (
    input  wire                                  clock,
    input  wire                                  reset,
    input  wire  rob_pkg::rob_entry_t [`ROB_N-1:0] head_entry,
    output logic [`ROB_IDX_W-1:0]                head,
    output logic [`ROB_CNT_W-1:0]                retire_count,
    output logic [`ROB_N-1:0]                    retire_valid,
    output logic [`ROB_N-1:0][`ROB_REG_W-1:0]    retire_dest,
    output logic [`ROB_N-1:0][`ROB_DATA_W-1:0]   retire_value,
    output logic                                 flush,
    output logic                                 redirect,
    output logic [`ROB_ADDR_W-1:0]               redirect_target,
    output logic                                 recovering
);

    import rob_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    ////////////////////////////////
    // Retire selection
    ////////////////////////////////
    always_comb begin
        logic run;       // Still inside the leading run
        logic mispred;
        run             = 1'b1;
        retire_count    = '0;
        flush           = 1'b0;
        redirect_target = '0;
        for (int i = 0; i < `ROB_N; i++) begin
            retire_valid[i] = run && head_entry[i].valid && head_entry[i].complete;
            retire_dest[i]  = head_entry[i].dest;
            retire_value[i] = head_entry[i].value;
            mispred = (head_entry[i].kind == kind_branch) &&
                      (head_entry[i].taken != head_entry[i].pred_taken);
            if (retire_valid[i]) begin
                retire_count = retire_count + `ROB_CNT_W'(1);
                if (mispred) begin
                    // Branch itself retires, nothing younger does
                    flush           = 1'b1;
                    redirect_target = head_entry[i].target;
                    run             = 1'b0;
                end
            end else begin
                run = 1'b0;      // Stop at first not-ready entry
            end
        end
    end

    assign redirect   = flush;
    assign recovering = (state == st_recover);

    ////////////////////////////////
    // Recovery FSM
    ////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            st_run:     if (flush) state_next = st_recover;
            st_recover: state_next = st_run;    // Front end refill slot
            default:    state_next = st_run;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_run;
            head  <= '0;
        end else begin
            state <= state_next;
            head  <= head + retire_count[`ROB_IDX_W-1:0];   // Wraps at ROB_SZ
        end
    end

endmodule

`default_nettype wire

// File: hw/rob_storage.sv
// Entry array of the reorder buffer
// Takes dispatch writes and completion results, shows the two head entries
// to the retire controller and drops retired or flushed entries

`default_nettype none

`include "rob_params.svh"

module rob_storage (
    input  wire                                   clock,
    input  wire                                   reset,

    // Dispatch
    input  wire  [`ROB_N-1:0]                     alloc_we,
    input  wire  [`ROB_N-1:0][`ROB_IDX_W-1:0]     alloc_idx,
    input  wire  rob_pkg::inst_kind_t [`ROB_N-1:0] dispatch_kind,
    input  wire  [`ROB_N-1:0][`ROB_REG_W-1:0]     dispatch_dest,
    input  wire  [`ROB_N-1:0]                     dispatch_pred_taken,

    // Completion
    input  wire  [`ROB_N-1:0]                     complete_valid,
    input  wire  [`ROB_N-1:0][`ROB_IDX_W-1:0]     complete_idx,
    input  wire  [`ROB_N-1:0][`ROB_DATA_W-1:0]    complete_value,
    input  wire  [`ROB_N-1:0]                     complete_taken,
    input  wire  [`ROB_N-1:0][`ROB_ADDR_W-1:0]    complete_target,

    // Retire
    input  wire  [`ROB_IDX_W-1:0]                 head,
    input  wire  [`ROB_CNT_W-1:0]                 retire_count,
    input  wire                                   flush,
    output rob_pkg::rob_entry_t [`ROB_N-1:0]      head_entry
);

    import rob_pkg::*;

    rob_entry_t [`ROB_SZ-1:0] entries;
    rob_entry_t [`ROB_SZ-1:0] entries_next;

    // Head window with slot 0 the oldest
    always_comb begin
        logic [`ROB_IDX_W-1:0] idx;
        for (int i = 0; i < `ROB_N; i++) begin
            idx           = head + `ROB_IDX_W'(i);
            head_entry[i] = entries[idx];
        end
    end

    ////////////////////////////////
    // Next array contents
    ////////////////////////////////
    always_comb begin
        logic [`ROB_IDX_W-1:0] idx;
        entries_next = entries;

        // Drop what retires this cycle
        for (int i = 0; i < `ROB_N; i++) begin
            idx = head + `ROB_IDX_W'(i);
            if (`ROB_CNT_W'(i) < retire_count)
                entries_next[idx].valid = 1'b0;
        end

        // Completion results, only for live entries
        for (int i = 0; i < `ROB_N; i++) begin
            idx = complete_idx[i];
            if (complete_valid[i] && entries[idx].valid) begin
                entries_next[idx].complete = 1'b1;
                entries_next[idx].value    = complete_value[i];
                if (entries[idx].kind == kind_branch) begin
                    entries_next[idx].taken  = complete_taken[i];
                    entries_next[idx].target = complete_target[i];
                end
            end
        end

        // New entries land at the tail, not yet complete
        for (int i = 0; i < `ROB_N; i++) begin
            idx = alloc_idx[i];
            if (alloc_we[i]) begin
                entries_next[idx].valid      = 1'b1;
                entries_next[idx].complete   = 1'b0;
                entries_next[idx].kind       = dispatch_kind[i];
                entries_next[idx].dest       = dispatch_dest[i];
                entries_next[idx].pred_taken = dispatch_pred_taken[i];
                entries_next[idx].taken      = 1'b0;
            end
        end

        // Misprediction kills everything still in flight,
        // including anything dispatched this same cycle
        if (flush) begin
            for (int i = 0; i < `ROB_SZ; i++)
                entries_next[i].valid = 1'b0;
        end
    end

    // Clear the valid bits on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ROB_SZ; i++)
                entries[i].valid <= 1'b0;
        end else begin
            entries <= entries_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/rob_top.sv
// Reorder buffer top level
// Dispatch and completion come in, in-order retire and the redirect go out

`default_nettype none

`include "rob_params.svh"

module rob_top (
    input  wire                                   clock,
    input  wire                                   reset,

    // Dispatch
    input  wire  [`ROB_N-1:0]                     dispatch_valid,
    input  wire  rob_pkg::inst_kind_t [`ROB_N-1:0] dispatch_kind,
    input  wire  [`ROB_N-1:0][`ROB_REG_W-1:0]     dispatch_dest,
    input  wire  [`ROB_N-1:0]                     dispatch_pred_taken,
    output logic                                  dispatch_accept,
    output logic [`ROB_N-1:0][`ROB_IDX_W-1:0]     alloc_idx,
    output logic [`ROB_CNT_W-1:0]                 free_slots,

    // Completion
    input  wire  [`ROB_N-1:0]                     complete_valid,
    input  wire  [`ROB_N-1:0][`ROB_IDX_W-1:0]     complete_idx,
    input  wire  [`ROB_N-1:0][`ROB_DATA_W-1:0]    complete_value,
    input  wire  [`ROB_N-1:0]                     complete_taken,
    input  wire  [`ROB_N-1:0][`ROB_ADDR_W-1:0]    complete_target,

    // Retire
    output logic [`ROB_N-1:0]                     retire_valid,
    output logic [`ROB_N-1:0][`ROB_REG_W-1:0]     retire_dest,
    output logic [`ROB_N-1:0][`ROB_DATA_W-1:0]    retire_value,
    output logic                                  redirect,
    output logic [`ROB_ADDR_W-1:0]                redirect_target
);

    import rob_pkg::*;

    logic [`ROB_N-1:0]      alloc_we;
    logic [`ROB_IDX_W-1:0]  head;          // Also the flush-time tail base
    logic [`ROB_CNT_W-1:0]  retire_count;
    logic                   flush;
    logic                   recovering;
    rob_entry_t [`ROB_N-1:0] head_entry;

    rob_alloc u_alloc (
        .clock           (clock),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .retire_count    (retire_count),
        .flush           (flush),
        .new_tail        (head),
        .recovering      (recovering),
        .alloc_idx       (alloc_idx),
        .dispatch_accept (dispatch_accept),
        .free_slots      (free_slots),
        .alloc_we        (alloc_we)
    );

    rob_storage u_storage (
        .clock               (clock),
        .reset               (reset),
        .alloc_we            (alloc_we),
        .alloc_idx           (alloc_idx),
        .dispatch_kind       (dispatch_kind),
        .dispatch_dest       (dispatch_dest),
        .dispatch_pred_taken (dispatch_pred_taken),
        .complete_valid      (complete_valid),
        .complete_idx        (complete_idx),
        .complete_value      (complete_value),
        .complete_taken      (complete_taken),
        .complete_target     (complete_target),
        .head                (head),
        .retire_count        (retire_count),
        .flush               (flush),
        .head_entry          (head_entry)
    );

    rob_retire_ctrl u_retire (
        .clock           (clock),
        .reset           (reset),
        .head_entry      (head_entry),
        .head            (head),
        .retire_count    (retire_count),
        .retire_valid    (retire_valid),
        .retire_dest     (retire_dest),
        .retire_value    (retire_value),
        .flush           (flush),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .recovering      (recovering)
    );

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/rob_pkg.sv
hw/rob_alloc.sv
hw/rob_storage.sv
hw/rob_retire_ctrl.sv
hw/rob_top.sv
tests/rob_tb.sv

// File: tests/rob_tb.sv
// Random testbench for the reorder buffer
// Plays the front end and the execute units and checks retire against an
// in-order model that lives here. Build with sim.f, top module rob_tb

`default_nettype none

`include "rob_params.svh"

module rob_tb;

    import rob_pkg::*;

    localparam int NUM_INSTS  = 400;
    localparam int MAX_CYCLES = NUM_INSTS * 10;     // Leaves room for flush stalls

    logic                                  clock;
    logic                                  reset;
    logic [`ROB_N-1:0]                     dispatch_valid;
    inst_kind_t [`ROB_N-1:0]               dispatch_kind;
    logic [`ROB_N-1:0][`ROB_REG_W-1:0]     dispatch_dest;
    logic [`ROB_N-1:0]                     dispatch_pred_taken;
    logic                                  dispatch_accept;
    logic [`ROB_N-1:0][`ROB_IDX_W-1:0]     alloc_idx;
    logic [`ROB_CNT_W-1:0]                 free_slots;
    logic [`ROB_N-1:0]                     complete_valid;
    logic [`ROB_N-1:0][`ROB_IDX_W-1:0]     complete_idx;
    logic [`ROB_N-1:0][`ROB_DATA_W-1:0]    complete_value;
    logic [`ROB_N-1:0]                     complete_taken;
    logic [`ROB_N-1:0][`ROB_ADDR_W-1:0]    complete_target;
    logic [`ROB_N-1:0]                     retire_valid;
    logic [`ROB_N-1:0][`ROB_REG_W-1:0]     retire_dest;
    logic [`ROB_N-1:0][`ROB_DATA_W-1:0]    retire_value;
    logic                                  redirect;
    logic [`ROB_ADDR_W-1:0]                redirect_target;

    //////////////////////////////
    // Reference model state
    //////////////////////////////
    logic [`ROB_IDX_W-1:0]   order_q[$];            // Live slots, oldest first
    inst_kind_t              m_kind   [`ROB_SZ];
    logic [`ROB_REG_W-1:0]   m_dest   [`ROB_SZ];
    logic                    m_pred   [`ROB_SZ];
    logic                    m_taken  [`ROB_SZ];
    logic                    m_done   [`ROB_SZ];    // Completion seen
    logic [`ROB_DATA_W-1:0]  m_value  [`ROB_SZ];
    logic [`ROB_ADDR_W-1:0]  m_target [`ROB_SZ];
    logic [`ROB_IDX_W-1:0]   m_head;
    logic [`ROB_IDX_W-1:0]   m_tail;                // Next slot to hand out
    logic                    m_recover;             // Refill cycle after a flush
    int                      errors;
    int                      cycles;
    int                      issued;                // Accepted dispatches

    rob_top u_dut (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_kind       (dispatch_kind),
        .dispatch_dest       (dispatch_dest),
        .dispatch_pred_taken (dispatch_pred_taken),
        .dispatch_accept     (dispatch_accept),
        .alloc_idx           (alloc_idx),
        .free_slots          (free_slots),
        .complete_valid      (complete_valid),
        .complete_idx        (complete_idx),
        .complete_value      (complete_value),
        .complete_taken      (complete_taken),
        .complete_target     (complete_target),
        .retire_valid        (retire_valid),
        .retire_dest         (retire_dest),
        .retire_value        (retire_value),
        .redirect            (redirect),
        .redirect_target     (redirect_target)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic clear_inputs();
        dispatch_valid      = '0;
        dispatch_dest       = '0;
        dispatch_pred_taken = '0;
        complete_valid      = '0;
        complete_idx        = '0;
        complete_value      = '0;
        complete_taken      = '0;
        complete_target     = '0;
        for (int i = 0; i < `ROB_N; i++)
            dispatch_kind[i] = kind_alu;
    endtask

    // Falling edge stimulus for one cycle
    task automatic drive_cycle();
        logic [`ROB_IDX_W-1:0] cand[$];   // Live and still waiting on a result
        int pick;
        clear_inputs();
        if (issued < NUM_INSTS) begin
            dispatch_valid = `ROB_N'($urandom_range(0, 3));     // Gaps allowed
            for (int i = 0; i < `ROB_N; i++) begin
                dispatch_kind[i]       = ($urandom_range(0, 3) == 0) ? kind_branch : kind_alu;
                dispatch_dest[i]       = `ROB_REG_W'($urandom);
                dispatch_pred_taken[i] = 1'($urandom);
            end
        end
        foreach (order_q[j])
            if (!m_done[order_q[j]]) cand.push_back(order_q[j]);
        for (int i = 0; i < `ROB_N; i++) begin
            if (cand.size() > 0 && $urandom_range(0, 1) == 1) begin
                pick               = $urandom_range(0, cand.size() - 1);   // Any order
                complete_valid[i]  = 1'b1;
                complete_idx[i]    = cand[pick];
                complete_value[i]  = $urandom;
                complete_taken[i]  = 1'($urandom);
                complete_target[i] = $urandom;
                cand.delete(pick);                  // No index twice in a cycle
            end
        end
    endtask

    //////////////////////////////
    // Pre-edge check and model step
    //////////////////////////////
    task automatic check_and_update();
        logic                    exp_accept;
        logic                    exp_redirect;
        logic [`ROB_N-1:0]       exp_ret;
        logic [`ROB_ADDR_W-1:0]  exp_target;
        logic [`ROB_IDX_W-1:0]   next_idx;
        logic [`ROB_IDX_W-1:0]   slot;
        logic                    run;
        int                      n_valid;
        int                      n_ret;

        // Allocation side against model occupancy
        n_valid    = $countones(dispatch_valid);
        exp_accept = !m_recover && (n_valid <= `ROB_SZ - order_q.size());
        check_value("dispatch_accept", 32'(dispatch_accept), 32'(exp_accept));
        check_value("free_slots", 32'(free_slots), 32'(`ROB_SZ - order_q.size()));
        next_idx = m_tail;
        for (int i = 0; i < `ROB_N; i++) begin
            if (dispatch_valid[i]) begin
                check_value($sformatf("alloc_idx[%0d]", i), 32'(alloc_idx[i]), 32'(next_idx));
                next_idx = next_idx + 1'b1;     // Wraps at 8
            end
        end

        // Leading run of completed entries up to a mispredicted branch
        run          = 1'b1;
        n_ret        = 0;
        exp_ret      = '0;
        exp_redirect = 1'b0;
        exp_target   = '0;
        for (int i = 0; i < `ROB_N; i++) begin
            if (run && i < order_q.size() && m_done[order_q[i]]) begin
                slot       = order_q[i];
                exp_ret[i] = 1'b1;
                n_ret++;
                if (m_kind[slot] == kind_branch && m_taken[slot] != m_pred[slot]) begin
                    exp_redirect = 1'b1;
                    exp_target   = m_target[slot];
                    run          = 1'b0;
                end
            end else begin
                run = 1'b0;
            end
        end
        check_value("retire_valid", 32'(retire_valid), 32'(exp_ret));
        check_value("redirect", 32'(redirect), 32'(exp_redirect));
        if (exp_redirect)
            check_value("redirect_target", redirect_target, exp_target);
        for (int i = 0; i < `ROB_N; i++) begin
            if (exp_ret[i]) begin
                check_value($sformatf("retire_dest[%0d]", i), 32'(retire_dest[i]),
                            32'(m_dest[order_q[i]]));
                check_value($sformatf("retire_value[%0d]", i), retire_value[i],
                            m_value[order_q[i]]);
            end
        end

        // Step the model as the coming edge will
        for (int i = 0; i < n_ret; i++)
            void'(order_q.pop_front());
        m_head = m_head + `ROB_IDX_W'(n_ret);
        for (int i = 0; i < `ROB_N; i++) begin
            if (complete_valid[i]) begin
                slot           = complete_idx[i];
                m_done[slot]   = 1'b1;
                m_value[slot]  = complete_value[i];
                if (m_kind[slot] == kind_branch) begin   // ALU ignores direction
                    m_taken[slot]  = complete_taken[i];
                    m_target[slot] = complete_target[i];
                end
            end
        end
        if (exp_accept)
            issued = issued + n_valid;
        if (exp_redirect) begin
            order_q.delete();                // Younger work and same-cycle dispatch die
            m_tail = m_head;
        end else if (exp_accept) begin
            for (int i = 0; i < `ROB_N; i++) begin
                if (dispatch_valid[i]) begin
                    m_kind[m_tail]  = dispatch_kind[i];
                    m_dest[m_tail]  = dispatch_dest[i];
                    m_pred[m_tail]  = dispatch_pred_taken[i];
                    m_taken[m_tail] = 1'b0;
                    m_done[m_tail]  = 1'b0;
                    order_q.push_back(m_tail);
                    m_tail = m_tail + 1'b1;
                end
            end
        end
        m_recover = exp_redirect;
    endtask

    initial begin
        logic [31:0] seed_ret;
        errors    = 0;
        cycles    = 0;
        issued    = 0;
        m_head    = '0;
        m_tail    = '0;
        m_recover = 1'b0;
        seed_ret  = $urandom(32'h4030_47f6);
        reset     = 1'b1;
        clear_inputs();
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Buffer empty and open out of reset
        check_value("free_slots", 32'(free_slots), 32'(`ROB_SZ));
        check_value("retire_valid", 32'(retire_valid), 32'h0);
        check_value("redirect", 32'(redirect), 32'h0);
        check_value("dispatch_accept", 32'(dispatch_accept), 32'h1);

        while ((issued < NUM_INSTS || order_q.size() > 0) && cycles < MAX_CYCLES) begin
            drive_cycle();
            #1;                                     // Outputs settle mid cycle
            check_and_update();
            @(posedge clock);
            cycles++;
            @(negedge clock);
        end
        clear_inputs();

        if (issued < NUM_INSTS || order_q.size() > 0) begin
            errors++;
            $display("timeout: buffer not drained after %0d cycles, %0d instructions issued",
                     cycles, issued);
        end else begin
            check_value("free_slots", 32'(free_slots), 32'(`ROB_SZ));   // Drained
        end
        $display("errors: %0d, cycles: %0d, instructions: %0d", errors, cycles, issued);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
